// ==== rtl/test_data_pkg.sv ====
// Shared constants for the synthetic traffic test engine: line width, seed pattern and run timing
package test_data_pkg;

    // Width of one generated line in bits
    localparam int LINE_BITS = 512;

    // Reset pattern of the generator, one 64-bit word per lane
    // Software keeps the same table to predict the signature
    localparam logic [511:0] DATA_INIT = {
        64'h8644554624594bbf, 64'hb173761f0b5a083b,
        64'h76655f3e9ba84438, 64'hafcc6ba3db67f2b3,
        64'h33b23fb3ab3c4277, 64'h8519a51b2767a2fa,
        64'h54de0dc97b564cbf, 64'h860761722b164a00
    };

    // One 32-bit hash bucket per 32-bit slice of a line
    localparam int HASH_BUCKETS = LINE_BITS / 32;

    // Width of the requested line count and of the remaining-lines counter
    localparam int COUNT_BITS = 16;

    // Checker latency from the last accepted line to a settled hash
    localparam int DRAIN_CYCLES = 4;

    // Width of the drain counter
    localparam int DRAIN_BITS = $clog2(DRAIN_CYCLES);

    // Sequencer state encodings
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RESTART = 2'd1;
    localparam logic [1:0] ST_STREAM = 2'd2;
    localparam logic [1:0] ST_DRAIN = 2'd3;

endpackage

// ==== rtl/hash32.sv ====
// Single 32-bit hash bucket that folds a new slice in by rotate and XOR
`timescale 1ns/100ps

module hash32
(
    input  logic        clk,
    input  logic        reset,

    // Fold new_data into the bucket in this cycle
    input  logic        en,
    input  logic [31:0] new_data,

    // Current bucket contents
    output logic [31:0] value
);

    // The rotate spreads each input bit over all bucket positions as lines
    // accumulate, so that two equal slices in a row do not cancel out
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Every run starts from an empty bucket
            value <= '0;
        end
        else if (en)
        begin
            // Rotate left by one bit, then mix in the slice
            value <= {value[30:0], value[31]} ^ new_data;
        end
    end

endmodule

// ==== rtl/test_data_gen.sv ====
// Seeded line generator that derives each new line from the previous one and a 64-bit seed
`timescale 1ns/100ps

module test_data_gen
#(
    // Line width in bits, a power of two and at least 64
    parameter int DATA_WIDTH = test_data_pkg::LINE_BITS
)
(
    input  logic                  clk,

    // Reload the line from the seed, takes priority over gen_next
    input  logic                  reset,

    // Advance to the next line
    input  logic                  gen_next,
    input  logic [63:0]           seed,

    // Current line
    output logic [DATA_WIDTH-1:0] data
);

    import test_data_pkg::*;

    // Rotate a 64-bit word left by r bits
    // Doubling the word and shifting keeps the bits that wrap around
    function automatic logic [63:0] rotl64(input logic [63:0] v, input int r);
        logic [127:0] t;
        t = {v, v} << r;
        return t[127:64];
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Each 64-bit word takes its lane of the init pattern
            // The pattern repeats for lines wider than 512 bits
            // The seed is rotated by the word index so every lane differs
            for (int i = 0; i < DATA_WIDTH; i = i + 64)
            begin
                data[i +: 64] <= DATA_INIT[i % $bits(DATA_INIT) +: 64] ^
                                 rotl64(seed, i / 64);
            end
        end
        else if (gen_next)
        begin
            // Rotate every word left by one byte and mix in the rotated seed
            // The same rule is easy to repeat in software
            for (int i = 0; i < DATA_WIDTH; i = i + 64)
            begin
                data[i +: 64] <= {data[i +: 56], data[i + 56 +: 8]} ^
                                 rotl64(seed, i / 64);
            end
        end
    end

endmodule

// ==== rtl/test_data_chk.sv ====
// Line checker that hashes every accepted line into 32-bit buckets and reduces them to a signature
`timescale 1ns/100ps

module test_data_chk
#(
    // Line width in bits, a power of two and at least 128
    parameter int DATA_WIDTH = test_data_pkg::LINE_BITS
)
(
    input  logic                  clk,

    // Clears the buckets at the start of a run
    input  logic                  reset,

    // Line strobe and line data
    input  logic                  new_data_en,
    input  logic [DATA_WIDTH-1:0] new_data,

    // Signature, settled four cycles after the last enabled line
    output logic [63:0]           hash
);

    // Input stage, registered to ease timing from the generator
    logic                                  bucket_en;
    logic [DATA_WIDTH/32-1:0][31:0]        bucket_data;

    // Bucket contents
    logic [DATA_WIDTH/32-1:0][31:0]        bucket_value;

    // Pairwise XOR of neighbouring buckets
    logic [DATA_WIDTH/64-1:0][31:0]        pair_xor;

    // Two 32-bit halves of the folded signature
    logic [31:0]                           fold_low;
    logic [31:0]                           fold_high;

    // The enable is control state and clears with the buckets
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bucket_en <= 1'b0;
        end
        else
        begin
            bucket_en <= new_data_en;
        end
    end

    // Line data is only looked at when the enable is set
    always_ff @(posedge clk)
    begin
        bucket_data <= new_data;
    end

    // One bucket per 32-bit slice of the line
    genvar b;
    generate
        for (b = 0; b < DATA_WIDTH / 32; b = b + 1)
        begin : g_bucket
            hash32 hash32_inst
            (
                .clk      (clk),
                .reset    (reset),
                .en       (bucket_en),
                .new_data (bucket_data[b]),
                .value    (bucket_value[b])
            );
        end
    endgenerate

    // First reduction step halves the number of words and is registered
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < DATA_WIDTH / 64; i = i + 1)
        begin
            pair_xor[i] <= bucket_value[2 * i] ^ bucket_value[2 * i + 1];
        end
    end

    // Lower pairs fold into the low half and upper pairs into the high half
    // With sixteen buckets this is buckets 0 to 7 and buckets 8 to 15
    always_comb
    begin
        fold_low = '0;
        fold_high = '0;
        for (int i = 0; i < DATA_WIDTH / 128; i = i + 1)
        begin
            fold_low = fold_low ^ pair_xor[i];
            fold_high = fold_high ^ pair_xor[i + DATA_WIDTH / 128];
        end
    end

    // Output register, the reader waits for the run to drain before sampling
    always_ff @(posedge clk)
    begin
        hash <= {fold_high, fold_low};
    end

endmodule

// ==== rtl/test_run_ctrl.sv ====
// Run sequencer that accepts a start, strobes the requested number of lines, drains and signals done
`timescale 1ns/100ps

module test_run_ctrl
(
    input  logic                              clk,
    input  logic                              reset,

    // Run request, only taken while no run is active
    input  logic                              start,
    input  logic [63:0]                       seed,
    input  logic [test_data_pkg::COUNT_BITS-1:0] line_count,

    // Holds the line stream without losing lines
    input  logic                              pause,

    // Run status
    output logic                              busy,
    output logic                              done,

    // Generator and checker control
    output logic                              gen_restart,
    output logic                              gen_next,
    output logic [63:0]                       run_seed
);

    import test_data_pkg::*;

    logic [1:0]            state;
    logic [COUNT_BITS-1:0] remaining;
    logic [DRAIN_BITS-1:0] drain_cnt;
    logic                  accept;

    // Done is the last drain cycle, busy drops in the same cycle
    assign done = (state == ST_DRAIN) && (drain_cnt == DRAIN_BITS'(DRAIN_CYCLES - 1));
    assign busy = (state != ST_IDLE) && !done;

    // A start is taken in idle or in the done cycle of the previous run
    assign accept = start && !busy;

    // One line per unpaused streaming cycle
    assign gen_next = (state == ST_STREAM) && !pause;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            remaining <= '0;
            // Pulse the restart after reset so the generator and checker come up clean
            gen_restart <= 1'b1;
        end
        else
        begin
            // The restart follows the accepting cycle
            gen_restart <= accept;
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                        state <= ST_RESTART;
                end
                ST_RESTART:
                begin
                    // A zero-line run goes straight to drain
                    state <= (remaining == '0) ? ST_DRAIN : ST_STREAM;
                end
                ST_STREAM:
                begin
                    if (gen_next)
                    begin
                        remaining <= remaining - 1'b1;
                        if (remaining == COUNT_BITS'(1))
                            state <= ST_DRAIN;
                    end
                end
                default:
                begin
                    // Drain, wait out the checker pipeline
                    if (done)
                        state <= accept ? ST_RESTART : ST_IDLE;
                end
            endcase
            if (accept)
                remaining <= line_count;
        end
    end

    // Counts drain cycles, held at zero outside the drain state
    always_ff @(posedge clk)
    begin
        if (reset || (state != ST_DRAIN))
            drain_cnt <= '0;
        else
            drain_cnt <= drain_cnt + 1'b1;
    end

    // The seed is also taken during reset, so the post-reset reload uses the seed input
    always_ff @(posedge clk)
    begin
        if (reset || accept)
            run_seed <= seed;
    end

endmodule

// ==== rtl/test_data_top.sv ====
// Top level of the traffic test engine joining the run sequencer, line generator and checker
`timescale 1ns/100ps

module test_data_top
(
    input  logic                                 clk,
    input  logic                                 reset,

    // Run request
    input  logic                                 start,
    input  logic [63:0]                          seed,
    input  logic [test_data_pkg::COUNT_BITS-1:0] line_count,
    input  logic                                 pause,

    // Run status and result
    output logic                                 busy,
    output logic                                 done,
    output logic [63:0]                          hash,
    output logic [63:0]                          data_low
);

    import test_data_pkg::*;

    logic                 gen_restart;
    logic                 gen_next;
    logic [63:0]          run_seed;
    logic [LINE_BITS-1:0] gen_data;

    test_run_ctrl test_run_ctrl_inst
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .seed        (seed),
        .line_count  (line_count),
        .pause       (pause),
        .busy        (busy),
        .done        (done),
        .gen_restart (gen_restart),
        .gen_next    (gen_next),
        .run_seed    (run_seed)
    );

    // The restart pulse reloads the generator from the latched seed
    test_data_gen #(.DATA_WIDTH(LINE_BITS)) test_data_gen_inst
    (
        .clk      (clk),
        .reset    (gen_restart),
        .gen_next (gen_next),
        .seed     (run_seed),
        .data     (gen_data)
    );

    // The checker hashes the same line the generator is leaving, one bucket per slice
    test_data_chk #(.DATA_WIDTH(HASH_BUCKETS * 32)) test_data_chk_inst
    (
        .clk         (clk),
        .reset       (gen_restart),
        .new_data_en (gen_next),
        .new_data    (gen_data),
        .hash        (hash)
    );

    // Low word of the current line, for a cheap check of the generator state
    assign data_low = gen_data[63:0];

endmodule

// ==== dv/test_data_sva.sv ====
// Run sequencer assertions covering the done pulse, line strobes and the strobe count of each run
`timescale 1ns/100ps

module test_data_sva
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 accept,
    input  logic                                 pause,
    input  logic                                 busy,
    input  logic                                 done,
    input  logic                                 gen_next,
    input  logic [test_data_pkg::COUNT_BITS-1:0] line_count
);

    import test_data_pkg::*;

    // Count requested by the run in progress and strobes seen so far
    logic [COUNT_BITS-1:0] latched_count;
    logic [COUNT_BITS-1:0] strobe_count;

    // Assertion failures seen so far
    int failures = 0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            latched_count <= '0;
            strobe_count <= '0;
        end
        else if (accept)
        begin
            latched_count <= line_count;
            strobe_count <= '0;
        end
        else if (gen_next)
        begin
            strobe_count <= strobe_count + 1'b1;
        end
    end

    // Done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else
    begin
        $error("done held for more than one cycle");
        failures++;
    end

    // No strobe while paused or while no run is active
    strobe_when_allowed: assert property (@(posedge clk) disable iff (reset)
        gen_next |-> (!pause && busy))
    else
    begin
        $error("gen_next high while paused or idle");
        failures++;
    end

    // A run strobes exactly the count that it latched
    strobe_total: assert property (@(posedge clk) disable iff (reset)
        done |-> (strobe_count == latched_count))
    else
    begin
        $error("strobe count differs from the requested line count");
        failures++;
    end

    // Done only ends a run that has been busy through its drain
    done_after_drain: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(busy, DRAIN_CYCLES))
    else
    begin
        $error("done without a full drain");
        failures++;
    end

endmodule

// ==== dv/test_data_tb.sv ====
// Testbench for the traffic test engine that runs the vector file and checks hash and line data
`timescale 1ns/100ps

module test_data_tb;

    import test_data_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic [63:0]           seed;
    logic [COUNT_BITS-1:0] line_count;
    logic                  pause;
    logic                  busy;
    logic                  done;
    logic [63:0]           hash;
    logic [63:0]           data_low;

    // Vector memory holds the number of tests in word 0 and then five words per test
    logic [63:0] vec_mem [0:255];

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    test_data_top test_data_top_inst
    (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .seed       (seed),
        .line_count (line_count),
        .pause      (pause),
        .busy       (busy),
        .done       (done),
        .hash       (hash),
        .data_low   (data_low)
    );

    bind test_run_ctrl test_data_sva test_data_sva_inst
    (
        .clk        (clk),
        .reset      (reset),
        .accept     (accept),
        .pause      (pause),
        .busy       (busy),
        .done       (done),
        .gen_next   (gen_next),
        .line_count (line_count)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // Rotate a 64-bit word left by a small number of bits
    function automatic logic [63:0] rot_left(input logic [63:0] v, input int r);
        if (r == 0)
            return v;
        return (v << r) | (v >> (64 - r));
    endfunction

    // Reference model built from the generator and hash rules
    task automatic predict(input logic [63:0] s, input int n,
                           output logic [63:0] exp_hash, output logic [63:0] exp_low);
        logic [63:0] w [0:7];
        logic [31:0] bk [0:15];
        logic [31:0] sl;
        logic [31:0] lo;
        logic [31:0] hi;
        for (int k = 0; k < 8; k++)
            w[k] = DATA_INIT[64 * k +: 64] ^ rot_left(s, k);
        for (int b = 0; b < 16; b++)
            bk[b] = '0;
        for (int line = 0; line < n; line++)
        begin
            // Hash the current line, then step every word
            for (int b = 0; b < 16; b++)
            begin
                sl = (b % 2 == 1) ? w[b / 2][63:32] : w[b / 2][31:0];
                bk[b] = {bk[b][30:0], bk[b][31]} ^ sl;
            end
            for (int k = 0; k < 8; k++)
                w[k] = {w[k][55:0], w[k][63:56]} ^ rot_left(s, k);
        end
        lo = '0;
        hi = '0;
        for (int b = 0; b < 8; b++)
        begin
            lo = lo ^ bk[b];
            hi = hi ^ bk[b + 8];
        end
        exp_hash = {hi, lo};
        exp_low = w[0];
    endtask

    // Compare one value and report a mismatch
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Run one test from the vector file
    task automatic run_test(input int idx);
        logic [63:0] v_seed;
        logic [63:0] v_mode;
        logic [63:0] exp_hash;
        logic [63:0] exp_low;
        int          n;
        int          cycles;
        int          limit;
        bit          got_done;
        v_seed = vec_mem[1 + idx * 5];
        n = int'(vec_mem[2 + idx * 5][COUNT_BITS-1:0]);
        v_mode = vec_mem[3 + idx * 5];
        if (v_mode[4])
        begin
            exp_hash = vec_mem[4 + idx * 5];
            exp_low = vec_mem[5 + idx * 5];
        end
        else
            predict(v_seed, n, exp_hash, exp_low);
        test_errors = 0;
        limit = 4 * n + 100;

        // Start cycle
        @(posedge clk);
        #2;
        seed = v_seed;
        line_count = COUNT_BITS'(n);
        pause = 1'b0;
        start = 1'b1;
        cycles = 0;
        got_done = 1'b0;
        while (!got_done && cycles < limit)
        begin
            @(posedge clk);
            #2;
            start = 1'b0;
            seed = v_seed;
            pause = v_mode[0] ? (($urandom % 3) == 0) : 1'b0;
            // A second request in the middle of the run must be ignored
            if (v_mode[1] && cycles == 2)
            begin
                start = 1'b1;
                seed = ~v_seed;
                line_count = COUNT_BITS'(1);
            end
            @(negedge clk);
            cycles++;
            got_done = done;
        end

        if (!got_done)
        begin
            $display("Test %0d timed out waiting for done after %0d cycles", idx, cycles);
            errors++;
            test_errors++;
        end
        else
        begin
            check_value("hash", hash, exp_hash);
            check_value("data_low", data_low, exp_low);
            check_value("busy", {63'd0, busy}, 64'd0);
            if (!v_mode[0])
                check_value("done_cycles", 64'(cycles), 64'(n + 5));
        end

        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("Test %0d seed %h lines %0d mode %0h cycles %0d: %s", idx, v_seed, n,
                 v_mode[7:0], cycles, (test_errors == 0) ? "ok" : "FAIL");
    endtask

    initial
    begin
        int num_tests;
        int sva_failures;
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        seed = '0;
        line_count = '0;
        pause = 1'b0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'h3f31));
        $readmemh("dv/test_data_vectors.txt", vec_mem);
        num_tests = int'(vec_mem[0][7:0]);

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // After reset the generator holds the reload of the seed input
        @(negedge clk);
        check_value("busy", {63'd0, busy}, 64'd0);
        check_value("done", {63'd0, done}, 64'd0);
        repeat (4) @(negedge clk);
        check_value("hash", hash, 64'd0);
        check_value("data_low", data_low, DATA_INIT[63:0] ^ seed);
        tests_run++;
        if (errors != 0)
            tests_failed++;
        $display("Reset state: %s", (errors == 0) ? "ok" : "FAIL");

        for (int t = 0; t < num_tests; t++)
            run_test(t);

        // Protocol assertion failures count as errors of the run
        sva_failures = test_data_top_inst.test_run_ctrl_inst.test_data_sva_inst.failures;
        errors = errors + sva_failures;

        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, sva_failures);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== dv/test_data_vectors.txt ====
// Word 0 is the number of tests, then one test per line
// Columns: seed, line count, mode (bit0 random pause, bit1 start while busy,
// bit4 expected values below, else from the rule model), expected hash, expected data_low
9
0000000000000000 0000 10 0000000000000000 860761722b164a00
0123456789abcdef 0001 00 0000000000000000 0000000000000000
0123456789abcdef 0003 00 0000000000000000 0000000000000000
fedcba9876543210 0040 00 0000000000000000 0000000000000000
fedcba9876543210 0040 01 0000000000000000 0000000000000000
0f1e2d3c4b5a6978 000a 02 0000000000000000 0000000000000000
1111111111111111 0005 00 0000000000000000 0000000000000000
2222222222222222 0005 00 0000000000000000 0000000000000000
a5a5a5a5a5a5a5a5 0000 10 0000000000000000 23a2c4d78eb3efa5

// ==== vlog.f ====
rtl/test_data_pkg.sv
rtl/hash32.sv
rtl/test_data_gen.sv
rtl/test_data_chk.sv
rtl/test_run_ctrl.sv
rtl/test_data_top.sv
dv/test_data_sva.sv
dv/test_data_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the traffic test engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module test_data_tb \
    -f vlog.f \
    --Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^all tests passed$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
